//--- cpuPkg.sv
package cpuPkg;

    // operation codes from the external master
    typedef enum logic [3:0] {
        opAdc,
        opSbc,
        opAnd,
        opOra,
        opEor,
        opLsr,
        opLda,
        opSec,
        opClc,
        opSed,
        opCld,
        opClv,
        opNop
    } opCodeT;

    typedef logic [7:0] byteT;

    // raw adder output, before decimal adjust
    typedef struct packed {
        byteT sum;
        logic carry;
        logic halfCarry;
        logic overflow;
    } aluResultT;

    // status bit positions, NV-BDIZC order
    localparam int flagN = 7;
    localparam int flagV = 6;
    localparam int flagD = 3;
    localparam int flagZ = 1;
    localparam int flagC = 0;

    // only bit 5 set out of reset
    localparam byteT statusReset = 8'h20;

    // decimal adjust constants
    localparam byteT bcdLowAdj = 8'h06;
    localparam byteT bcdHighAdj = 8'h60;
    localparam byteT bcdMaxLow = 8'h09;
    localparam byteT bcdMaxByte = 8'h99;

    // sequencer phases
    typedef enum logic [1:0] {
        sIdle,
        sLoad,
        sExec,
        sWrite
    } seqStateT;

endpackage

//--- dpCtrlIf.sv
interface dpCtrlIf
    import cpuPkg::*;
();

    // phase strobes, each high for one cycle in order
    logic loadOp;
    logic execOp;
    logic writeOp;

    // operation latched when the start was accepted
    opCodeT curOp;

    modport seq (
        output loadOp,
        output execOp,
        output writeOp,
        output curOp
    );

    modport dp (
        input loadOp,
        input execOp,
        input writeOp,
        input curOp
    );

endinterface

//--- opSequencer.sv
module opSequencer
    import cpuPkg::*;
(
    input  logic   phi2,
    input  logic   rstAll,
    input  logic   opStart,
    input  opCodeT opCode,
    output logic   busy,
    output logic   opDone,
    dpCtrlIf.seq   ctrl
);

    seqStateT state;
    seqStateT stateNext;
    opCodeT   opLatch;
    logic     accept;

    // start only counts while idle
    assign accept = (state == sIdle) && opStart;

    // one state per cycle, no waiting anywhere
    always_comb begin
        stateNext = state;
        case (state)
            sIdle: begin
                if (accept) begin
                    stateNext = sLoad;
                end
            end
            sLoad: stateNext = sExec;
            sExec: stateNext = sWrite;
            sWrite: stateNext = sIdle;
            default: stateNext = sIdle;
        endcase
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            state <= sIdle;
            opDone <= 1'b0;
            opLatch <= opNop;
        end else begin
            state <= stateNext;
            // done pulses on the way back to idle
            opDone <= (state == sWrite);
            if (accept) begin
                opLatch <= opCode;
            end
        end
    end

    assign busy = (state != sIdle);

    // strobes straight from the state
    assign ctrl.loadOp = (state == sLoad);
    assign ctrl.execOp = (state == sExec);
    assign ctrl.writeOp = (state == sWrite);
    assign ctrl.curOp = opLatch;

endmodule

//--- opCounter.sv
module opCounter (
    input  logic        phi2,
    input  logic        rstAll,
    dpCtrlIf.dp         ctrl,
    output logic [15:0] opCount
);

    logic [7:0] lowByte;
    logic [7:0] highByte;
    logic [8:0] lowSum;
    logic       lowCarry;

    // low incrementer, its carry steps the high half
    assign lowSum = {1'b0, lowByte} + 9'd1;
    assign lowCarry = lowSum[8];

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            lowByte <= 8'h00;
            highByte <= 8'h00;
        end else if (ctrl.writeOp) begin
            lowByte <= lowSum[7:0];
            // wraps to zero after 0xffff
            highByte <= highByte + {7'd0, lowCarry};
        end
    end

    assign opCount = {highByte, lowByte};

endmodule

//--- aluCore.sv
module aluCore
    import cpuPkg::*;
(
    input  logic      phi2,
    input  logic      rstAll,
    dpCtrlIf.dp       ctrl,
    input  byteT      operand,
    input  byteT      acc,
    input  logic      carryIn,
    output aluResultT aluOut
);

    byteT       operandReg;
    byteT       addend;
    logic [4:0] lowSum;
    logic [8:0] fullSum;

    // operand captured in the load phase
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            operandReg <= 8'h00;
        end else if (ctrl.loadOp) begin
            operandReg <= operand;
        end
    end

    // subtract is add of the inverted operand, carry as not-borrow
    assign addend = (ctrl.curOp == opSbc) ? ~operandReg : operandReg;

    // half carry from the low nibble, carry-in included
    assign lowSum = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'd0, carryIn};
    assign fullSum = {1'b0, acc} + {1'b0, addend} + {8'd0, carryIn};

    always_comb begin
        aluOut = '0;
        case (ctrl.curOp)
            opAdc, opSbc: begin
                aluOut.sum = fullSum[7:0];
                aluOut.carry = fullSum[8];
                aluOut.halfCarry = lowSum[4];
                // same-sign addends, sum sign flipped
                aluOut.overflow = (acc[7] == addend[7]) && (fullSum[7] != acc[7]);
            end
            opAnd: aluOut.sum = acc & operandReg;
            opOra: aluOut.sum = acc | operandReg;
            opEor: aluOut.sum = acc ^ operandReg;
            opLsr: begin
                // zero in at the top, bit 0 out to carry
                aluOut.sum = {1'b0, acc[7:1]};
                aluOut.carry = acc[0];
            end
            opLda: aluOut.sum = operandReg;
            // flag ops and nop leave the accumulator value
            default: aluOut.sum = acc;
        endcase
    end

endmodule

//--- accumAdjust.sv
module accumAdjust
    import cpuPkg::*;
(
    input  logic      phi2,
    input  logic      rstAll,
    dpCtrlIf.dp       ctrl,
    input  aluResultT aluOut,
    input  logic      decMode,
    output byteT      acc,
    output byteT      newAcc,
    output logic      heldCarry,
    output logic      heldOverflow
);

    aluResultT holdReg;
    byteT      adjusted;
    logic      adjCarry;
    logic      writesAcc;

    // adder hold register, filled in the exec phase
    always_ff @(posedge phi2) begin
        if (ctrl.execOp) begin
            holdReg <= aluOut;
        end
    end

    // decimal adjust works on the held sum and flags
    always_comb begin
        adjusted = holdReg.sum;
        adjCarry = holdReg.carry;
        if (decMode && (ctrl.curOp == opAdc)) begin
            if (({4'h0, holdReg.sum[3:0]} > bcdMaxLow) || holdReg.halfCarry) begin
                adjusted = adjusted + bcdLowAdj;
            end
            // high digit overflowed, bcd carry out
            if (holdReg.carry || (holdReg.sum > bcdMaxByte)) begin
                adjusted = adjusted + bcdHighAdj;
                adjCarry = 1'b1;
            end
        end else if (decMode && (ctrl.curOp == opSbc)) begin
            // borrow from a digit means it needs the adjust
            if (!holdReg.halfCarry) begin
                adjusted = adjusted - bcdLowAdj;
            end
            if (!holdReg.carry) begin
                adjusted = adjusted - bcdHighAdj;
            end
        end
    end

    // flag ops and nop keep the accumulator
    always_comb begin
        case (ctrl.curOp)
            opSec, opClc, opSed, opCld, opClv, opNop: writesAcc = 1'b0;
            default: writesAcc = 1'b1;
        endcase
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            acc <= 8'h00;
        end else if (ctrl.writeOp && writesAcc) begin
            acc <= adjusted;
        end
    end

    assign newAcc = adjusted;
    assign heldCarry = adjCarry;
    assign heldOverflow = holdReg.overflow;

endmodule

//--- statusFlags.sv
module statusFlags
    import cpuPkg::*;
(
    input  logic phi2,
    input  logic rstAll,
    dpCtrlIf.dp  ctrl,
    input  byteT newAcc,
    input  logic heldCarry,
    input  logic heldOverflow,
    output byteT status
);

    byteT statusReg;
    logic negNext;
    logic zeroNext;

    // N and Z follow the value being written this cycle
    assign negNext = newAcc[7];
    assign zeroNext = (newAcc == 8'h00);

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            statusReg <= statusReset;
        end else if (ctrl.writeOp) begin
            case (ctrl.curOp)
                opAdc, opSbc: begin
                    statusReg[flagN] <= negNext;
                    statusReg[flagZ] <= zeroNext;
                    statusReg[flagC] <= heldCarry;
                    statusReg[flagV] <= heldOverflow;
                end
                opLsr: begin
                    statusReg[flagN] <= negNext;
                    statusReg[flagZ] <= zeroNext;
                    statusReg[flagC] <= heldCarry;
                end
                opAnd, opOra, opEor, opLda: begin
                    statusReg[flagN] <= negNext;
                    statusReg[flagZ] <= zeroNext;
                end
                // single-flag ops
                opSec: statusReg[flagC] <= 1'b1;
                opClc: statusReg[flagC] <= 1'b0;
                opSed: statusReg[flagD] <= 1'b1;
                opCld: statusReg[flagD] <= 1'b0;
                opClv: statusReg[flagV] <= 1'b0;
                // nop touches nothing
                default: begin
                end
            endcase
        end
    end

    // bits 5, 4 and 2 never written, so bit 5 stays set
    assign status = statusReg;

endmodule

//--- execUnit.sv
module execUnit
    import cpuPkg::*;
(
    input  logic        phi2,
    input  logic        rstAll,
    input  logic        opStart,
    input  opCodeT      opCode,
    input  byteT        operand,
    output logic        busy,
    output logic        opDone,
    output byteT        acc,
    output byteT        status,
    output logic [15:0] opCount
);

    // phase strobes and latched op to the data modules
    dpCtrlIf ctrl ();

    aluResultT aluOut;
    byteT      newAcc;
    logic      heldCarry;
    logic      heldOverflow;

    opSequencer uSeq (
        .phi2(phi2),
        .rstAll(rstAll),
        .opStart(opStart),
        .opCode(opCode),
        .busy(busy),
        .opDone(opDone),
        .ctrl(ctrl.seq)
    );

    opCounter uCount (
        .phi2(phi2),
        .rstAll(rstAll),
        .ctrl(ctrl.dp),
        .opCount(opCount)
    );

    // carry-in comes from the C flag
    aluCore uAlu (
        .phi2(phi2),
        .rstAll(rstAll),
        .ctrl(ctrl.dp),
        .operand(operand),
        .acc(acc),
        .carryIn(status[flagC]),
        .aluOut(aluOut)
    );

    // D flag selects decimal adjust
    accumAdjust uAcc (
        .phi2(phi2),
        .rstAll(rstAll),
        .ctrl(ctrl.dp),
        .aluOut(aluOut),
        .decMode(status[flagD]),
        .acc(acc),
        .newAcc(newAcc),
        .heldCarry(heldCarry),
        .heldOverflow(heldOverflow)
    );

    statusFlags uFlags (
        .phi2(phi2),
        .rstAll(rstAll),
        .ctrl(ctrl.dp),
        .newAcc(newAcc),
        .heldCarry(heldCarry),
        .heldOverflow(heldOverflow),
        .status(status)
    );

endmodule

//--- execUnit_props.sv
module execUnitProps
    import cpuPkg::*;
(
    input logic        phi2,
    input logic        rstAll,
    input logic        opStart,
    input opCodeT      opCode,
    input byteT        operand,
    input logic        busy,
    input logic        opDone,
    input byteT        acc,
    input byteT        status,
    input logic [15:0] opCount
);

    timeunit 1ns;
    timeprecision 100ps;

    // shadow state, stepped on the same edges as the unit
    byteT        expAcc;
    byteT        expStatus;
    logic [15:0] expCount;
    logic        expDone;
    logic [1:0]  stg;
    opCodeT      pendOp;
    byteT        pendOperand;
    int          failCount = 0;

    // next {acc, status} from the 6502 rules for one operation
    function automatic logic [15:0] applyOp(opCodeT op, byteT a, byteT b, byteT p);
        int   sum;
        int   low;
        int   sgn;
        byteT addend;
        byteT r;
        byteT q;
        logic c;
        logic v;
        logic nz;
        r = a;
        q = p;
        c = p[flagC];
        v = p[flagV];
        nz = 1'b1;
        case (op)
            opAdc, opSbc: begin
                // subtract adds the one's complement, C acts as not-borrow
                addend = (op == opSbc) ? ~b : b;
                sum = int'(a) + int'(addend) + int'(c);
                low = int'(a[3:0]) + int'(addend[3:0]) + int'(c);
                // overflow from the signed view of both addends
                sgn = int'($signed(a)) + int'($signed(addend)) + int'(c);
                v = (sgn > 127) || (sgn < -128);
                r = byteT'(sum);
                if (p[flagD] && (op == opAdc)) begin
                    if (((sum & 15) > int'(bcdMaxLow)) || (low > 15)) begin
                        r = r + bcdLowAdj;
                    end
                    // high test on the byte before the low adjust
                    c = (sum > 255) || ((sum & 255) > int'(bcdMaxByte));
                    if (c) begin
                        r = r + bcdHighAdj;
                    end
                end else begin
                    c = (sum > 255);
                    if (p[flagD]) begin
                        // digit borrows need the subtract adjust
                        if (low < 16) begin
                            r = r - bcdLowAdj;
                        end
                        if (!c) begin
                            r = r - bcdHighAdj;
                        end
                    end
                end
            end
            opAnd: r = a & b;
            opOra: r = a | b;
            opEor: r = a ^ b;
            opLsr: begin
                c = a[0];
                r = a >> 1;
            end
            opLda: r = b;
            opSec: begin
                c = 1'b1;
                nz = 1'b0;
            end
            opClc: begin
                c = 1'b0;
                nz = 1'b0;
            end
            opSed: begin
                q[flagD] = 1'b1;
                nz = 1'b0;
            end
            opCld: begin
                q[flagD] = 1'b0;
                nz = 1'b0;
            end
            opClv: begin
                v = 1'b0;
                nz = 1'b0;
            end
            default: nz = 1'b0;
        endcase
        if (nz) begin
            q[flagN] = r[7];
            q[flagZ] = (r == 8'h00);
        end
        q[flagC] = c;
        q[flagV] = v;
        return {r, q};
    endfunction

    // stg 0 idle, 1 operand pending, 2 exec, 3 write
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            expAcc <= 8'h00;
            expStatus <= statusReset;
            expCount <= 16'h0000;
            expDone <= 1'b0;
            stg <= 2'd0;
            pendOp <= opNop;
            pendOperand <= 8'h00;
        end else begin
            expDone <= (stg == 2'd3);
            case (stg)
                2'd0: begin
                    if (opStart) begin
                        pendOp <= opCode;
                        stg <= 2'd1;
                    end
                end
                // operand is taken one edge after the start
                2'd1: begin
                    pendOperand <= operand;
                    stg <= 2'd2;
                end
                2'd2: stg <= 2'd3;
                default: begin
                    {expAcc, expStatus} <= applyOp(pendOp, expAcc, pendOperand, expStatus);
                    expCount <= expCount + 16'd1;
                    stg <= 2'd0;
                end
            endcase
        end
    end

    pReset: assert property (@(posedge phi2)
        rstAll |=> (!busy && !opDone && (acc == 8'h00) && (status == statusReset)
                    && (opCount == 16'h0000)))
    else begin
        $error("FAIL %0t: outputs not at reset values", $time);
        failCount++;
    end

    pLatency: assert property (@(posedge phi2) disable iff (rstAll)
        opDone |-> $past(opStart && !busy, 4))
    else begin
        $error("FAIL %0t: done without a start accepted 3 cycles before", $time);
        failCount++;
    end

    pDone: assert property (@(posedge phi2) disable iff (rstAll) opDone == expDone)
    else begin
        $error("FAIL %0t: opDone %0b, expected %0b", $time, $sampled(opDone),
               $sampled(expDone));
        failCount++;
    end

    pBusy: assert property (@(posedge phi2) disable iff (rstAll) busy == (stg != 2'd0))
    else begin
        $error("FAIL %0t: busy %0b out of step with the operation", $time, $sampled(busy));
        failCount++;
    end

    pAcc: assert property (@(posedge phi2) disable iff (rstAll) opDone |-> acc == expAcc)
    else begin
        $error("FAIL %0t: acc %02h, expected %02h", $time, $sampled(acc), $sampled(expAcc));
        failCount++;
    end

    // ignored starts must leave the accumulator alone
    pAccHeld: assert property (@(posedge phi2) disable iff (rstAll) !opDone |-> $stable(acc))
    else begin
        $error("FAIL %0t: acc changed outside opDone", $time);
        failCount++;
    end

    pStatus: assert property (@(posedge phi2) disable iff (rstAll)
        opDone |-> status == expStatus)
    else begin
        $error("FAIL %0t: status %02h, expected %02h", $time, $sampled(status),
               $sampled(expStatus));
        failCount++;
    end

    pBit5: assert property (@(posedge phi2) disable iff (rstAll) status[5])
    else begin
        $error("FAIL %0t: status bit 5 reads 0", $time);
        failCount++;
    end

    pCount: assert property (@(posedge phi2) disable iff (rstAll)
        opDone |-> (opCount == expCount) && (opCount == $past(opCount) + 16'd1))
    else begin
        $error("FAIL %0t: opCount %04h, expected %04h", $time, $sampled(opCount),
               $sampled(expCount));
        failCount++;
    end

    pCountHeld: assert property (@(posedge phi2) disable iff (rstAll)
        !opDone |-> $stable(opCount))
    else begin
        $error("FAIL %0t: opCount changed outside opDone", $time);
        failCount++;
    end

endmodule

bind execUnit execUnitProps uProps (
    .phi2(phi2),
    .rstAll(rstAll),
    .opStart(opStart),
    .opCode(opCode),
    .operand(operand),
    .busy(busy),
    .opDone(opDone),
    .acc(acc),
    .status(status),
    .opCount(opCount)
);

//--- tbExecUnit.sv
module tbExecUnit
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int numDirected = 24;
    localparam int numRandom = 300;
    // reset, 4 cycles per operation, then slack
    localparam int cycleLimit = 10 + 4 * (numDirected + numRandom) + 50;

    logic        phi2;
    logic        rstAll;
    logic        opStart;
    opCodeT      opCode;
    byteT        operand;
    logic        busy;
    logic        opDone;
    byteT        acc;
    byteT        status;
    logic [15:0] opCount;

    int seed = 88987;
    int cycleCount = 0;
    int errors;

    execUnit uut (
        .phi2(phi2),
        .rstAll(rstAll),
        .opStart(opStart),
        .opCode(opCode),
        .operand(operand),
        .busy(busy),
        .opDone(opDone),
        .acc(acc),
        .status(status),
        .opCount(opCount)
    );

    initial phi2 = 1'b0;
    always #2 phi2 = ~phi2;

    // hang guard
    always @(posedge phi2) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("run timed out after %0d cycles without finishing", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic opCodeT pickOp();
        int idx;
        idx = $unsigned($random(seed)) % 13;
        return opCodeT'(idx[3:0]);
    endfunction

    // one operation from a negedge with the unit idle, back at the done cycle
    task automatic runOp(input opCodeT op, input byteT value, input bit noise);
        opStart = 1'b1;
        opCode = op;
        operand = value;
        @(negedge phi2);
        opStart = 1'b0;
        if (noise) begin
            // start during exec, after the operand was taken
            @(negedge phi2);
            opStart = 1'b1;
            opCode = pickOp();
            operand = byteT'($random(seed));
            @(negedge phi2);
            opStart = 1'b0;
        end
        while (!opDone) begin
            @(negedge phi2);
        end
    endtask

    initial begin
        rstAll = 1'b1;
        opStart = 1'b0;
        opCode = opNop;
        operand = 8'h00;
        repeat (10) @(posedge phi2);
        @(negedge phi2);
        rstAll = 1'b0;

        // binary arithmetic, overflow both ways
        runOp(opLda, 8'h50, 1'b0);
        runOp(opAdc, 8'h50, 1'b0);
        runOp(opClv, 8'h00, 1'b0);
        runOp(opSec, 8'h00, 1'b1);
        runOp(opSbc, 8'h30, 1'b0);
        runOp(opSbc, 8'hf0, 1'b0);
        // logic and shift
        runOp(opAnd, 8'h0f, 1'b0);
        runOp(opOra, 8'h81, 1'b0);
        runOp(opEor, 8'hff, 1'b0);
        runOp(opLsr, 8'h00, 1'b0);
        runOp(opLsr, 8'h00, 1'b1);
        runOp(opLda, 8'h00, 1'b0);
        runOp(opClc, 8'h00, 1'b0);
        // decimal mode, 09+01, 99+01, 10-01
        runOp(opSed, 8'h00, 1'b0);
        runOp(opLda, 8'h09, 1'b0);
        runOp(opAdc, 8'h01, 1'b0);
        runOp(opLda, 8'h99, 1'b0);
        runOp(opClc, 8'h00, 1'b0);
        runOp(opAdc, 8'h01, 1'b0);
        runOp(opLda, 8'h10, 1'b0);
        runOp(opSec, 8'h00, 1'b0);
        runOp(opSbc, 8'h01, 1'b1);
        runOp(opCld, 8'h00, 1'b0);
        runOp(opNop, 8'h55, 1'b1);

        // random phase also carries the count into the high byte
        for (int i = 0; i < numRandom; i++) begin
            runOp(pickOp(), byteT'($random(seed)), (($random(seed) & 3) == 0));
        end

        repeat (4) @(negedge phi2);
        errors = uut.uProps.failCount;
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
cpuPkg.sv
dpCtrlIf.sv
opSequencer.sv
opCounter.sv
aluCore.sv
accumAdjust.sv
statusFlags.sv
execUnit.sv
execUnit_props.sv
tbExecUnit.sv

//--- Makefile
TOP = tbExecUnit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f flist.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
